// File: files.f
logic/hacd_pkg.sv
logic/hacd_regs.sv
logic/hacd_page_tracker.sv
logic/hacd_mc_forward.sv
logic/hacd.sv
sim/hacd_props.sv
sim/hacd_tb.sv

// File: sim/hacd_vectors.txt
// op(0 idle,1 reg wr,2 reg rd,3 cpu rd,4 cpu wr) mode addr wdata wstrb
// exp: rdata error mc_valid mc_addr infl defl, sampled one cycle after the step
1 0 00000004 0000000C F 00000000 0 0 00000000 0 0
2 0 00000004 00000000 0 0000000C 0 0 00000000 0 0
1 0 00000008 0000ABCD 1 00000000 0 0 00000000 0 0
2 0 00000008 00000000 0 000000CD 0 0 00000000 0 0
1 0 00000008 00003300 2 00000000 0 0 00000000 0 0
2 0 00000008 00000000 0 000033CD 0 0 00000000 0 0
2 0 00000014 00000000 0 00000000 1 0 00000000 0 0
1 0 00000008 00000030 3 00000000 0 0 00000000 0 0
4 0 00004010 11112222 0 00000000 0 1 00004010 0 0
3 3 00005020 00000000 0 00000000 0 1 00005020 0 0
2 3 0000000C 00000000 0 00000010 0 0 00000000 0 0
3 1 00000000 00000000 0 00000000 0 1 00000000 0 0
3 1 00001000 00000000 0 00000000 0 1 00001000 0 0
3 1 00002000 00000000 0 00000000 0 1 00002000 0 0
3 1 00003000 00000000 0 00000000 0 1 00003000 0 0
3 1 00006000 00000000 0 00000000 0 1 00006000 0 0
0 1 00000000 00000000 0 00000000 0 0 00000000 0 1
2 1 0000000C 00000000 0 004F000B 0 0 00000000 0 1
1 1 00000000 00000001 1 00000000 0 0 00000000 0 1
0 1 00000000 00000000 0 00000000 0 0 00000000 0 1
0 1 00000000 00000000 0 00000000 0 0 00000000 0 0
3 2 00004100 00000000 0 00000000 0 0 00000000 1 0
4 2 00007200 CAFEF00D 0 00000000 0 1 00007200 1 0
2 2 00000010 00000000 0 00000001 0 0 00000000 1 0
4 2 00005008 00000055 0 00000000 0 0 00000000 1 0
2 2 00000010 00000000 0 00000002 0 0 00000000 1 0
1 2 00000000 00000002 1 00000000 0 0 00000000 1 0
0 2 00000000 00000000 0 00000000 0 0 00000000 0 0
3 1 00008000 00000000 0 00000000 0 1 00008000 0 0
4 1 00009004 01234567 0 00000000 0 1 00009004 0 0
3 1 0000A008 00000000 0 00000000 0 1 0000A008 0 1
0 1 00000000 00000000 0 00000000 0 0 00000000 0 1
0 0 00000000 00000000 0 00000000 0 0 00000000 0 0

// File: sim/hacd_tb.sv
//////////////////////////////////////////////////
// Testbench for the compression helper
// Replays stimulus lines from the vector file
// Output checks, closing summary, watchdog
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module hacd_tb;

  import hacd_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int NUM_FIELDS = 11;
  localparam int MAX_STEPS  = 64;

  // Step kinds in column 0 of the vector file
  localparam logic [31:0] OP_IDLE   = 32'd0;
  localparam logic [31:0] OP_REG_WR = 32'd1;
  localparam logic [31:0] OP_REG_RD = 32'd2;
  localparam logic [31:0] OP_CPU_RD = 32'd3;
  localparam logic [31:0] OP_CPU_WR = 32'd4;

  logic       clk;
  logic       rst;
  hawk_mode_e mode;
  reg_req_t   req;
  reg_resp_t  resp;
  cpu_req_t   cpu_req;
  cpu_req_t   mc_req;
  logic       infl_irq;
  logic       defl_irq;

  // Flat field memory with NUM_FIELDS words per step
  logic [31:0] vec_mem [0:NUM_FIELDS*MAX_STEPS-1];
  int          num_steps;
  bit          vectors_loaded;
  int          error_cnt;
  int          check_cnt;

  hacd i_hacd (
    .clk_i            (clk),
    .rst_i            (rst),
    .hawk_sw_ctrl_i   (mode),
    .req_i            (req),
    .resp_o           (resp),
    .cpu_req_i        (cpu_req),
    .mc_req_o         (mc_req),
    .infl_interrupt_o (infl_irq),
    .defl_interrupt_o (defl_irq)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  function automatic logic [31:0] vec_field(input int step, input int col);
    return vec_mem[step*NUM_FIELDS + col];
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    check_cnt++;
    assert (act === exp) else begin
      error_cnt++;
      $display("Error: %s expected %h, got %h at %0t", name, exp, act, $time);
    end
  endtask

  //////////////////////////////////////////////////
  // Step drive and compare
  //////////////////////////////////////////////////

  task automatic drive_step(input int step);
    logic [31:0] op;
    logic [31:0] strb;
    op   = vec_field(step, 0);
    strb = vec_field(step, 4);
    mode = hawk_mode_e'(vec_field(step, 1) & 32'h3);
    // Every request is a one-cycle pulse
    req     = '0;
    cpu_req = '0;
    if (op == OP_REG_WR || op == OP_REG_RD) begin
      req.valid = 1'b1;
      req.write = (op == OP_REG_WR);
      req.addr  = vec_field(step, 2);
      req.wdata = vec_field(step, 3);
      req.wstrb = strb[3:0];
    end else if (op == OP_CPU_RD || op == OP_CPU_WR) begin
      cpu_req.valid = 1'b1;
      cpu_req.write = (op == OP_CPU_WR);
      cpu_req.addr  = vec_field(step, 2);
      cpu_req.wdata = vec_field(step, 3);
    end else begin
      assert (op == OP_IDLE) else begin
        error_cnt++;
        $display("Vector step %0d holds an unknown operation", step);
      end
    end
  endtask

  // Outputs one cycle after the step was driven
  task automatic compare_step(input int step);
    logic [31:0] op;
    logic        is_reg;
    op     = vec_field(step, 0);
    is_reg = (op == OP_REG_WR) || (op == OP_REG_RD);
    check_value("resp_o.ready", 32'(is_reg), 32'(resp.ready));
    if (is_reg) begin
      check_value("resp_o.error", vec_field(step, 6), 32'(resp.error));
    end
    if (op == OP_REG_RD) begin
      check_value("resp_o.rdata", vec_field(step, 5), resp.rdata);
    end
    check_value("mc_req_o.valid", vec_field(step, 7), 32'(mc_req.valid));
    // Forwarded payload must match what the CPU sent
    if (vec_field(step, 7) != 32'd0) begin
      check_value("mc_req_o.addr", vec_field(step, 8), mc_req.addr);
      check_value("mc_req_o.write", 32'(op == OP_CPU_WR), 32'(mc_req.write));
      check_value("mc_req_o.wdata", vec_field(step, 3), mc_req.wdata);
    end
    check_value("infl_interrupt_o", vec_field(step, 9), 32'(infl_irq));
    check_value("defl_interrupt_o", vec_field(step, 10), 32'(defl_irq));
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    rst            = 1'b1;
    mode           = MODE_PASS;
    req            = '0;
    cpu_req        = '0;
    error_cnt      = 0;
    check_cnt      = 0;
    num_steps      = 0;
    vectors_loaded = 1'b0;
    $readmemh("sim/hacd_vectors.txt", vec_mem);
    // Unfilled entries stay unknown
    while (num_steps < MAX_STEPS && !$isunknown(vec_mem[num_steps*NUM_FIELDS])) begin
      num_steps++;
    end
    vectors_loaded = 1'b1;
    assert (num_steps > 0) else begin
      error_cnt++;
      $display("Vector file sim/hacd_vectors.txt holds no usable steps");
    end
    repeat (5) @(posedge clk);
    #1;
    // Quiet outputs while in reset
    check_value("resp_o.ready", 32'd0, 32'(resp.ready));
    check_value("mc_req_o.valid", 32'd0, 32'(mc_req.valid));
    check_value("infl_interrupt_o", 32'd0, 32'(infl_irq));
    check_value("defl_interrupt_o", 32'd0, 32'(defl_irq));
    rst = 1'b0;
    for (int i = 0; i < num_steps; i++) begin
      @(posedge clk);
      #1;
      if (i > 0) begin
        compare_step(i - 1);
      end
      drive_step(i);
    end
    @(posedge clk);
    #1;
    if (num_steps > 0) begin
      compare_step(num_steps - 1);
    end
    $display("Steps: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
             num_steps, check_cnt, error_cnt, i_hacd.u_props.fail_cnt);
    if (error_cnt == 0 && i_hacd.u_props.fail_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Watchdog allows ten cycles per step plus margin
  initial begin
    wait (vectors_loaded);
    repeat (num_steps * 10 + 100) @(posedge clk);
    $display("Timeout after %0d cycles, the run did not complete", num_steps * 10 + 100);
    $display("Steps: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
             num_steps, check_cnt, error_cnt, i_hacd.u_props.fail_cnt);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/hacd_props.sv
//////////////////////////////////////////////////
// Concurrent assertions bound to the top level
// Bus response timing, guard blocking, reset
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module hacd_props (
  input logic                 clk_i,
  input logic                 rst_i,
  input hacd_pkg::hawk_mode_e hawk_sw_ctrl_i,
  input hacd_pkg::reg_req_t   req_i,
  input hacd_pkg::reg_resp_t  resp_o,
  input hacd_pkg::cpu_req_t   cpu_req_i,
  input hacd_pkg::cpu_req_t   mc_req_o,
  input hacd_pkg::hacd_cfg_t  cfg_i,
  input logic                 infl_interrupt_o,
  input logic                 defl_interrupt_o
);

  import hacd_pkg::*;

  logic guarded_hit;

  // Failed assertion count
  int   fail_cnt = 0;

  // Request that guard mode must stop
  assign guarded_hit = cpu_req_i.valid && (hawk_sw_ctrl_i == MODE_GUARD) &&
                       cfg_i.cmp_mask[cpu_req_i.addr[PAGE_LSB +: PAGE_IDX_W]];

  ready_after_req: assert property (@(posedge clk_i) disable iff (rst_i)
    req_i.valid |=> resp_o.ready)
    else begin
      $error("Register bus ready missing one cycle after a request");
      fail_cnt++;
    end

  ready_only_for_req: assert property (@(posedge clk_i) disable iff (rst_i)
    resp_o.ready |-> $past(req_i.valid))
    else begin
      $error("Register bus ready without a preceding request");
      fail_cnt++;
    end

  no_mc_for_guarded: assert property (@(posedge clk_i) disable iff (rst_i)
    guarded_hit |=> !mc_req_o.valid)
    else begin
      $error("Memory controller request issued for a guarded compressed page");
      fail_cnt++;
    end

  // Reset held over two edges lets registered flags settle
  irq_low_in_reset: assert property (@(posedge clk_i)
    rst_i && $past(rst_i) |-> !infl_interrupt_o && !defl_interrupt_o)
    else begin
      $error("Interrupt high while in reset");
      fail_cnt++;
    end

endmodule

bind hacd hacd_props u_props (
  .clk_i            (clk_i),
  .rst_i            (rst_i),
  .hawk_sw_ctrl_i   (hawk_sw_ctrl_i),
  .req_i            (req_i),
  .resp_o           (resp_o),
  .cpu_req_i        (cpu_req_i),
  .mc_req_o         (mc_req_o),
  .cfg_i            (cfg),
  .infl_interrupt_o (infl_interrupt_o),
  .defl_interrupt_o (defl_interrupt_o)
);

`default_nettype wire

// File: logic/hacd.sv
//////////////////////////////////////////////////
// Top level of the compression helper
// Register bank, page tracker, request forwarder
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module hacd (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  hacd_pkg::hawk_mode_e hawk_sw_ctrl_i,
  // Register bus
  input  hacd_pkg::reg_req_t   req_i,
  output hacd_pkg::reg_resp_t  resp_o,
  // CPU in, memory controller out
  input  hacd_pkg::cpu_req_t   cpu_req_i,
  output hacd_pkg::cpu_req_t   mc_req_o,
  // Interrupts
  output logic                 infl_interrupt_o,
  output logic                 defl_interrupt_o
);

  import hacd_pkg::*;

  // Config fan-out
  hacd_cfg_t   cfg;

  // Status back into the register bank
  logic [4:0]  free_cnt;
  logic [15:0] touched;
  logic [15:0] blocked_cnt;

  hacd_regs u_regs (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .req_i         (req_i),
    .resp_o        (resp_o),
    .free_cnt_i    (free_cnt),
    .touched_i     (touched),
    .blocked_cnt_i (blocked_cnt),
    .cfg_o         (cfg)
  );

  hacd_page_tracker u_tracker (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .cpu_req_i        (cpu_req_i),
    .mode_i           (hawk_sw_ctrl_i),
    .cfg_i            (cfg),
    .touched_o        (touched),
    .free_cnt_o       (free_cnt),
    .defl_interrupt_o (defl_interrupt_o)
  );

  hacd_mc_forward u_forward (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .cpu_req_i        (cpu_req_i),
    .mode_i           (hawk_sw_ctrl_i),
    .cfg_i            (cfg),
    .mc_req_o         (mc_req_o),
    .infl_interrupt_o (infl_interrupt_o),
    .blocked_cnt_o    (blocked_cnt)
  );

endmodule

`default_nettype wire

// File: logic/hacd_mc_forward.sv
//////////////////////////////////////////////////
// Forwarder toward the memory controller
// Pass or block per request, sticky inflate flag
// Saturating blocked-access counter
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module hacd_mc_forward (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  hacd_pkg::cpu_req_t   cpu_req_i,
  input  hacd_pkg::hawk_mode_e mode_i,
  input  hacd_pkg::hacd_cfg_t  cfg_i,
  output hacd_pkg::cpu_req_t   mc_req_o,
  output logic                 infl_interrupt_o,
  output logic [15:0]          blocked_cnt_o
);

  import hacd_pkg::*;

  logic [PAGE_IDX_W-1:0] page_idx;
  logic                  blocked;

  // Outgoing request stage
  logic                  mc_vld_q;
  logic                  mc_write_q;
  logic [31:0]           mc_addr_q;
  logic [31:0]           mc_wdata_q;

  logic                  infl_q;
  logic [15:0]           blocked_cnt_q;

  assign page_idx = cpu_req_i.addr[PAGE_LSB +: PAGE_IDX_W];

  // Guard mode stops any access to a compressed page
  assign blocked = cpu_req_i.valid && (mode_i == MODE_GUARD) &&
                   cfg_i.cmp_mask[page_idx];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mc_vld_q      <= 1'b0;
      infl_q        <= 1'b0;
      blocked_cnt_q <= '0;
    end else begin
      mc_vld_q <= cpu_req_i.valid && !blocked;
      // New block wins over a clear in the same cycle
      if (blocked) begin
        infl_q <= 1'b1;
      end else if (cfg_i.clr_infl) begin
        infl_q <= 1'b0;
      end
      // Saturate at all ones
      if (blocked && (blocked_cnt_q != '1)) begin
        blocked_cnt_q <= blocked_cnt_q + 16'd1;
      end
    end
  end

  // Payload copied as is
  always_ff @(posedge clk_i) begin
    if (cpu_req_i.valid) begin
      mc_write_q <= cpu_req_i.write;
      mc_addr_q  <= cpu_req_i.addr;
      mc_wdata_q <= cpu_req_i.wdata;
    end
  end

  assign mc_req_o = '{valid: mc_vld_q,
                      write: mc_write_q,
                      addr:  mc_addr_q,
                      wdata: mc_wdata_q};

  assign infl_interrupt_o = infl_q;
  assign blocked_cnt_o    = blocked_cnt_q;

endmodule

`default_nettype wire

// File: logic/hacd_page_tracker.sv
//////////////////////////////////////////////////
// Touched-page tracker
// Bitmap of touched pages, registered free count
// Deflate level from watermark compare
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module hacd_page_tracker (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  hacd_pkg::cpu_req_t   cpu_req_i,
  input  hacd_pkg::hawk_mode_e mode_i,
  input  hacd_pkg::hacd_cfg_t  cfg_i,
  output logic [15:0]          touched_o,
  output logic [4:0]           free_cnt_o,
  output logic                 defl_interrupt_o
);

  import hacd_pkg::*;

  logic                  track_en;
  logic [PAGE_IDX_W-1:0] page_idx;

  // Bitmap, one bit per page
  logic [NUM_PAGES-1:0]  touched_d;
  logic [NUM_PAGES-1:0]  touched_q;

  // Clear-bit population count
  logic [4:0]            free_cnt_d;
  logic [4:0]            free_cnt_q;

  // Page index from address bits 15:12
  assign page_idx = cpu_req_i.addr[PAGE_LSB +: PAGE_IDX_W];

  // Track and guard both record touches
  always_comb begin
    case (mode_i)
      MODE_TRACK, MODE_GUARD: track_en = 1'b1;
      MODE_PASS, MODE_RSVD:   track_en = 1'b0;
      default:                track_en = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // Bitmap update
  //////////////////////////////////////////////////

  always_comb begin
    // Clear first so a touch in the same cycle is kept
    touched_d = cfg_i.clr_touched ? '0 : touched_q;
    if (cpu_req_i.valid && track_en) begin
      touched_d[page_idx] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      touched_q <= '0;
    end else begin
      touched_q <= touched_d;
    end
  end

  //////////////////////////////////////////////////
  // Free count, one cycle behind the bitmap
  //////////////////////////////////////////////////

  always_comb begin
    free_cnt_d = '0;
    for (int i = 0; i < NUM_PAGES; i++) begin
      if (!touched_q[i]) begin
        free_cnt_d = free_cnt_d + 5'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      // Empty bitmap means every page is free
      free_cnt_q <= 5'(NUM_PAGES);
    end else begin
      free_cnt_q <= free_cnt_d;
    end
  end

  // Level, only while tracking
  assign defl_interrupt_o = track_en && (free_cnt_q < cfg_i.low_wm);

  assign touched_o  = touched_q;
  assign free_cnt_o = free_cnt_q;

endmodule

`default_nettype wire

// File: logic/hacd_regs.sv
//////////////////////////////////////////////////
// Register bank for the compression helper
// Bus decode, byte strobes, read mux
// Clear pulses for bitmap and inflate state
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module hacd_regs (
  input  logic                clk_i,
  input  logic                rst_i,
  input  hacd_pkg::reg_req_t  req_i,
  output hacd_pkg::reg_resp_t resp_o,
  input  logic [4:0]          free_cnt_i,
  input  logic [15:0]         touched_i,
  input  logic [15:0]         blocked_cnt_i,
  output hacd_pkg::hacd_cfg_t cfg_o
);

  import hacd_pkg::*;

  // Write enables per register
  logic        wr_en;
  logic        wr_ctrl;
  logic        wr_wm;
  logic        wr_mask;

  // Decode and read mux
  logic        hit_any;
  logic [31:0] rdata_d;

  // Config state
  logic [4:0]  low_wm_q;
  logic [15:0] cmp_mask_q;
  logic        clr_touched_q;
  logic        clr_infl_q;

  // Response state
  logic        ready_q;
  logic        error_q;
  logic [31:0] rdata_q;

  assign wr_en   = req_i.valid && req_i.write;
  assign wr_ctrl = wr_en && (req_i.addr == REG_CTRL);
  assign wr_wm   = wr_en && (req_i.addr == REG_LOW_WM);
  assign wr_mask = wr_en && (req_i.addr == REG_CMP_MASK);

  //////////////////////////////////////////////////
  // Offset decode and read data
  //////////////////////////////////////////////////

  always_comb begin
    rdata_d = '0;
    hit_any = 1'b1;
    case (req_i.addr)
      // Ctrl bits are pulses, read back as zero
      REG_CTRL:     rdata_d = '0;
      REG_LOW_WM:   rdata_d = {27'b0, low_wm_q};
      REG_CMP_MASK: rdata_d = {16'b0, cmp_mask_q};
      // Touched bitmap on top, free count at bottom
      REG_STATUS:   rdata_d = {touched_i, 11'b0, free_cnt_i};
      REG_BLOCKED:  rdata_d = {16'b0, blocked_cnt_i};
      default:      hit_any = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // Config registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      low_wm_q      <= '0;
      cmp_mask_q    <= '0;
      clr_touched_q <= 1'b0;
      clr_infl_q    <= 1'b0;
    end else begin
      // Watermark lives in byte 0
      if (wr_wm && req_i.wstrb[0]) begin
        low_wm_q <= req_i.wdata[4:0];
      end
      // Mask spans bytes 0 and 1
      if (wr_mask && req_i.wstrb[0]) begin
        cmp_mask_q[7:0] <= req_i.wdata[7:0];
      end
      if (wr_mask && req_i.wstrb[1]) begin
        cmp_mask_q[15:8] <= req_i.wdata[15:8];
      end
      // One-cycle pulses, high with ready
      clr_touched_q <= wr_ctrl && req_i.wstrb[0] && req_i.wdata[0];
      clr_infl_q    <= wr_ctrl && req_i.wstrb[0] && req_i.wdata[1];
    end
  end

  //////////////////////////////////////////////////
  // Response, one cycle after request
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ready_q <= 1'b0;
      error_q <= 1'b0;
    end else begin
      ready_q <= req_i.valid;
      error_q <= req_i.valid && !hit_any;
    end
  end

  // Read data sampled on every request
  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      rdata_q <= rdata_d;
    end
  end

  assign resp_o = '{ready: ready_q, error: error_q, rdata: rdata_q};

  assign cfg_o = '{low_wm:      low_wm_q,
                   cmp_mask:    cmp_mask_q,
                   clr_touched: clr_touched_q,
                   clr_infl:    clr_infl_q};

endmodule

`default_nettype wire

// File: logic/hacd_pkg.sv
//////////////////////////////////////////////////
// Shared definitions for the compression helper
// Page geometry, register offsets, mode enum
// Register bus, CPU request and config structs
//////////////////////////////////////////////////
`default_nettype none

package hacd_pkg;

  // Page geometry, 16 pages of 4 KB
  localparam int NUM_PAGES  = 16;
  localparam int PAGE_IDX_W = 4;
  localparam int PAGE_LSB   = 12;

  // Register byte offsets
  localparam logic [31:0] REG_CTRL     = 32'h0000_0000;
  localparam logic [31:0] REG_LOW_WM   = 32'h0000_0004;
  localparam logic [31:0] REG_CMP_MASK = 32'h0000_0008;
  localparam logic [31:0] REG_STATUS   = 32'h0000_000C;
  localparam logic [31:0] REG_BLOCKED  = 32'h0000_0010;

  // Operating mode from software control pins
  typedef enum logic [1:0] {
    MODE_PASS  = 2'd0,
    MODE_TRACK = 2'd1,
    MODE_GUARD = 2'd2,
    MODE_RSVD  = 2'd3
  } hawk_mode_e;

  //////////////////////////////////////////////////
  // Bus structs
  //////////////////////////////////////////////////

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } reg_req_t;

  typedef struct packed {
    logic        ready;
    logic        error;
    logic [31:0] rdata;
  } reg_resp_t;

  // CPU side, reused toward the memory controller
  typedef struct packed {
    logic        valid;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
  } cpu_req_t;

  // Config from the register bank
  typedef struct packed {
    logic [4:0]  low_wm;
    logic [15:0] cmp_mask;
    logic        clr_touched;
    logic        clr_infl;
  } hacd_cfg_t;

endpackage

`default_nettype wire
